//--- logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

   // fixed by the rv32i isa
   localparam int XLEN       = 32;
   localparam int NUM_REGS   = 32;
   localparam int REG_ADDR_W = 5;
   localparam int SHAMT_W    = 5;

   typedef logic [XLEN-1:0]       xlen_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [31:0]           instr_t;
   typedef logic [6:0]            opcode_t;
   typedef logic [2:0]            funct3_t;
   typedef logic [6:0]            funct7_t;

   // major opcodes handled by this slice
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_LUI    = 7'b0110111;

   // funct3 groups, shared by r-type and i-type
   localparam funct3_t F3_ADD_SUB = 3'b000;
   localparam funct3_t F3_SLL     = 3'b001;
   localparam funct3_t F3_SLT     = 3'b010;
   localparam funct3_t F3_SLTU    = 3'b011;
   localparam funct3_t F3_XOR     = 3'b100;
   localparam funct3_t F3_SRL_SRA = 3'b101;
   localparam funct3_t F3_OR      = 3'b110;
   localparam funct3_t F3_AND     = 3'b111;

   // funct7 values, alt selects sub / sra
   localparam funct7_t F7_BASE = 7'h00;
   localparam funct7_t F7_ALT  = 7'h20;

   // alu operations; pass_b carries the lui immediate through
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_e;

endpackage

`default_nettype wire

//--- logic/reg_read_if.sv
`timescale 1ns/100ps
`default_nettype none

interface reg_read_if;
   import rv_exec_pkg::*;

   // read addresses from the decoder
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   // read data, combinational from the addresses
   xlen_t     rs1_data;
   xlen_t     rs2_data;

   modport decoder (
      output rs1_addr,
      output rs2_addr
   );

   modport regfile (
      input  rs1_addr,
      input  rs2_addr,
      output rs1_data,
      output rs2_data
   );

endinterface

`default_nettype wire

//--- logic/decoded_op_if.sv
`timescale 1ns/100ps
`default_nettype none

interface decoded_op_if;
   import rv_exec_pkg::*;

   // from the decoder
   logic      valid;
   alu_op_e   op;
   reg_addr_t rd;
   reg_addr_t rs1;
   reg_addr_t rs2;
   xlen_t     imm;
   logic      use_imm;
   // register file values, wired in at the top
   xlen_t     rs1_data;
   xlen_t     rs2_data;

   modport decoder (
      output valid,
      output op,
      output rd,
      output rs1,
      output rs2,
      output imm,
      output use_imm
   );

   // execute side only reads
   modport execute (
      input valid,
      input op,
      input rd,
      input rs1,
      input rs2,
      input imm,
      input use_imm,
      input rs1_data,
      input rs2_data
   );

endinterface

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
   input  logic                instr_valid,
   input  rv_exec_pkg::instr_t instr,
   output logic                illegal,
   reg_read_if.decoder         rd_port,
   decoded_op_if.decoder       dec
);
   import rv_exec_pkg::*;

   opcode_t opcode;
   funct3_t funct3;
   funct7_t funct7;
   xlen_t   imm_i;
   xlen_t   imm_u;
   logic    bad_enc;
   alu_op_e op_sel;
   logic    use_imm_sel;
   xlen_t   imm_sel;

   // base operation for a funct3 group, funct7 clear
   function automatic alu_op_e base_op(input funct3_t f3);
      case (f3)
         F3_ADD_SUB: return ALU_ADD;
         F3_SLL:     return ALU_SLL;
         F3_SLT:     return ALU_SLT;
         F3_SLTU:    return ALU_SLTU;
         F3_XOR:     return ALU_XOR;
         F3_SRL_SRA: return ALU_SRL;
         F3_OR:      return ALU_OR;
         default:    return ALU_AND;
      endcase
   endfunction

   // field split
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // i-type sign extended, u-type upper 20 bits
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_u = {instr[31:12], 12'h000};

   always_comb begin
      bad_enc     = 1'b0;
      op_sel      = base_op(funct3);
      use_imm_sel = 1'b0;
      imm_sel     = imm_i;
      case (opcode)
         OPC_OP: begin
            // alt funct7 only valid for sub and sra
            if (funct7 == F7_ALT) begin
               if (funct3 == F3_ADD_SUB) begin
                  op_sel = ALU_SUB;
               end else if (funct3 == F3_SRL_SRA) begin
                  op_sel = ALU_SRA;
               end else begin
                  bad_enc = 1'b1;
               end
            end else if (funct7 != F7_BASE) begin
               bad_enc = 1'b1;
            end
         end
         OPC_OP_IMM: begin
            use_imm_sel = 1'b1;
            // shift immediates keep funct7 in imm[11:5]
            if (funct3 == F3_SLL) begin
               bad_enc = (funct7 != F7_BASE);
            end else if (funct3 == F3_SRL_SRA) begin
               if (funct7 == F7_ALT) begin
                  op_sel = ALU_SRA;
               end else if (funct7 != F7_BASE) begin
                  bad_enc = 1'b1;
               end
            end
         end
         OPC_LUI: begin
            op_sel      = ALU_PASS_B;
            use_imm_sel = 1'b1;
            imm_sel     = imm_u;
         end
         default: begin
            bad_enc = 1'b1;
         end
      endcase
   end

   // flag only while an instruction is offered
   assign illegal = instr_valid && bad_enc;

   // register file addresses straight from the fields
   assign rd_port.rs1_addr = instr[19:15];
   assign rd_port.rs2_addr = instr[24:20];

   assign dec.valid   = instr_valid && !bad_enc;
   assign dec.op      = op_sel;
   assign dec.rd      = instr[11:7];
   assign dec.rs1     = instr[19:15];
   assign dec.rs2     = instr[24:20];
   assign dec.imm     = imm_sel;
   assign dec.use_imm = use_imm_sel;

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   we,
   input  rv_exec_pkg::reg_addr_t waddr,
   input  rv_exec_pkg::xlen_t     wdata,
   reg_read_if.regfile            rd_port
);
   import rv_exec_pkg::*;

   // x0 has no storage
   xlen_t regs [1:NUM_REGS-1];

   // clocked write, sync clear of the whole file
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // combinational reads, index 0 forced to zero
   assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
   assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

   // execute unit must filter rd == 0 before the write port
   we_not_x0: assert property (
      @(posedge clk) disable iff (!rst_n)
      we |-> (waddr != '0)
   ) else $error("register file write enable with x0 address");

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   decoded_op_if.execute          dec,
   output logic                   wb_valid,
   output rv_exec_pkg::reg_addr_t wb_rd,
   output rv_exec_pkg::xlen_t     wb_data,
   output logic                   we
);
   import rv_exec_pkg::*;

   logic               fwd_a;
   logic               fwd_b;
   xlen_t              op_a;
   xlen_t              rs2_val;
   xlen_t              op_b;
   logic [SHAMT_W-1:0] shamt;
   xlen_t              result;

   // register file write, x0 dropped here
   assign we = wb_valid && (wb_rd != '0);

   // bypass from writeback when the source matches its rd
   assign fwd_a = we && (dec.rs1 == wb_rd);
   assign fwd_b = we && (dec.rs2 == wb_rd);

   assign op_a    = fwd_a ? wb_data : dec.rs1_data;
   assign rs2_val = fwd_b ? wb_data : dec.rs2_data;
   assign op_b    = dec.use_imm ? dec.imm : rs2_val;

   // low bits of b only
   assign shamt = op_b[SHAMT_W-1:0];

   always_comb begin
      case (dec.op)
         ALU_ADD:    result = op_a + op_b;
         ALU_SUB:    result = op_a - op_b;
         ALU_SLL:    result = op_a << shamt;
         ALU_SLT:    result = xlen_t'($signed(op_a) < $signed(op_b));
         ALU_SLTU:   result = xlen_t'(op_a < op_b);
         ALU_XOR:    result = op_a ^ op_b;
         ALU_SRL:    result = op_a >> shamt;
         // arithmetic shift keeps the sign bit
         ALU_SRA:    result = xlen_t'($signed(op_a) >>> shamt);
         ALU_OR:     result = op_a | op_b;
         ALU_AND:    result = op_a & op_b;
         ALU_PASS_B: result = op_b;
         default:    result = '0;
      endcase
   end

   // writeback stage, one cycle after issue
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= dec.valid;
      end
   end

   // payload only loaded on a valid op
   always_ff @(posedge clk) begin
      if (dec.valid) begin
         wb_rd   <= dec.rd;
         wb_data <= result;
      end
   end

   // valid must stay resolved, it gates the bypass and the write
   wb_valid_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(wb_valid)
   ) else $error("wb_valid unknown after reset");

endmodule

`default_nettype wire

//--- logic/exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   instr_valid,
   input  rv_exec_pkg::instr_t    instr,
   output logic                   wb_valid,
   output rv_exec_pkg::reg_addr_t wb_rd,
   output rv_exec_pkg::xlen_t     wb_data,
   output logic                   illegal
);

   logic reg_we;

   reg_read_if   rd_bus ();
   decoded_op_if dec_bus ();

   // read data joins the decoded op
   assign dec_bus.rs1_data = rd_bus.rs1_data;
   assign dec_bus.rs2_data = rd_bus.rs2_data;

   instr_decoder decoder_i (
      .instr_valid (instr_valid),
      .instr       (instr),
      .illegal     (illegal),
      .rd_port     (rd_bus.decoder),
      .dec         (dec_bus.decoder)
   );

   // write port fed from the writeback stage
   register_file regfile_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .we      (reg_we),
      .waddr   (wb_rd),
      .wdata   (wb_data),
      .rd_port (rd_bus.regfile)
   );

   execute_unit exec_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .dec      (dec_bus.execute),
      .wb_valid (wb_valid),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data),
      .we       (reg_we)
   );

endmodule

`default_nettype wire

//--- verification/exec_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb;
   import rv_exec_pkg::*;

   localparam int WB_TIMEOUT = 8;

   logic      clk;
   logic      rst_n;
   logic      instr_valid;
   instr_t    instr;
   logic      wb_valid;
   reg_addr_t wb_rd;
   xlen_t     wb_data;
   logic      illegal;

   // reference registers, x0 never written
   xlen_t     model_regs [0:31];
   // writeback expected from the op in flight
   logic      pending;
   reg_addr_t exp_rd;
   xlen_t     exp_data;

   exec_core dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_valid    (wb_valid),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .illegal     (illegal)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "%s wrong", name);
      end
   endtask

   // instruction word builders
   function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd);
      return {imm, rs1, f3, rd, OPC_OP_IMM};
   endfunction

   function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd);
      return {imm, rd, OPC_LUI};
   endfunction

   function automatic reg_addr_t rand_reg();
      return reg_addr_t'($urandom_range(31, 0));
   endfunction

   // rv32i semantics of one op, model registers updated in issue order
   task automatic predict(input instr_t ins, output logic legal, output xlen_t res);
      logic [6:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      logic       alt;
      xlen_t      a;
      xlen_t      b;
      xlen_t      sra;
      opc   = ins[6:0];
      f3    = ins[14:12];
      f7    = ins[31:25];
      alt   = (f7 == 7'h20);
      a     = model_regs[ins[19:15]];
      b     = (opc == OPC_OP) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
      sra   = $signed(a) >>> b[4:0];
      legal = 1'b1;
      res   = '0;
      if (opc == OPC_LUI) begin
         res = {ins[31:12], 12'h000};
      end else if (opc != OPC_OP && opc != OPC_OP_IMM) begin
         legal = 1'b0;
      end else begin
         // funct7 counts for r-type and immediate shifts
         if (opc == OPC_OP || f3 == 3'd1 || f3 == 3'd5) begin
            legal = (f7 == 7'h00) || (alt && f3 == 3'd5) || (alt && f3 == 3'd0 && opc == OPC_OP);
         end
         case (f3)
            3'd0:    res = (alt && opc == OPC_OP) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
            3'd3:    res = {31'b0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = alt ? sra : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
         endcase
      end
      if (legal && ins[11:7] != 5'd0) begin
         model_regs[ins[11:7]] = res;
      end
   endtask

   task automatic expect_writeback();
      check("wb_valid", wb_valid, pending);
      if (pending) begin
         check("wb_rd", wb_rd, exp_rd);
         check("wb_data", wb_data, exp_data);
      end
   endtask

   // issue at the falling edge, previous op's writeback checked first
   task automatic send(input instr_t ins);
      logic  legal;
      xlen_t res;
      @(negedge clk);
      expect_writeback();
      instr_valid = 1'b1;
      instr       = ins;
      predict(ins, legal, res);
      pending  = legal;
      exp_rd   = ins[11:7];
      exp_data = res;
      // illegal is combinational, same cycle
      #1;
      check("illegal", illegal, !legal);
   endtask

   // idle the input, wait for the last writeback
   task automatic flush();
      int waited;
      @(negedge clk);
      instr_valid = 1'b0;
      instr       = instr_t'($urandom);
      waited      = 0;
      while (pending && !wb_valid) begin
         if (waited == WB_TIMEOUT) begin
            $display("timeout at %0t ns: writeback never came", $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "no writeback");
         end
         @(negedge clk);
         waited++;
      end
      check("wb latency", waited, 0);
      expect_writeback();
      pending = 1'b0;
      #1;
      check("illegal while idle", illegal, 0);
   endtask

   // lui then addi, upper part corrected for the sign of the low 12 bits
   task automatic load_reg(input reg_addr_t r, input xlen_t val);
      xlen_t upper;
      upper = val + {19'b0, val[11], 12'b0};
      send(u_type(upper[31:12], r));
      send(i_type(val[11:0], r, 3'd0, r));
   endtask

   // called right at the release, wb_valid still shows the last reset edge
   task automatic reset_state();
      #1;
      check("wb_valid after reset", wb_valid, 0);
      check("illegal after reset", illegal, 0);
      for (int n = 0; n < 32; n++) begin
         send(i_type(12'h000, reg_addr_t'(n), 3'd0, reg_addr_t'(n)));
      end
      flush();
   endtask

   task automatic imm_ops();
      logic [2:0]  f3;
      logic [11:0] imm;
      for (int r = 1; r < 32; r++) begin
         load_reg(reg_addr_t'(r), xlen_t'($urandom));
      end
      for (int i = 0; i < 80; i++) begin
         f3  = 3'(i % 8);
         imm = 12'($urandom);
         // shift amount in imm[4:0], funct7 above it
         if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
         end else if (f3 == 3'd5) begin
            imm[11:5] = (i % 16 < 8) ? 7'h00 : 7'h20;
         end
         send(i_type(imm, rand_reg(), f3, rand_reg()));
         if (i % 8 == 7) begin
            send(u_type(20'($urandom), rand_reg()));
         end
      end
      // negative immediates
      send(i_type(12'hfff, 5'd3, 3'd0, 5'd4));
      send(i_type(12'h800, 5'd3, 3'd2, 5'd5));
      send(i_type(12'hfff, 5'd3, 3'd3, 5'd6));
      flush();
   endtask

   task automatic reg_ops();
      logic [2:0] f3;
      logic [6:0] f7;
      load_reg(5'd1, 32'h8000_0000);
      load_reg(5'd2, 32'h7fff_ffff);
      load_reg(5'd3, 32'hffff_ffff);
      load_reg(5'd4, 32'h0000_001f);
      // slt vs sltu at the sign boundary
      send(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd10));
      send(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd11));
      send(r_type(7'h00, 5'd1, 5'd3, 3'd2, 5'd12));
      send(r_type(7'h00, 5'd1, 5'd3, 3'd3, 5'd13));
      // sra of negative values
      send(r_type(7'h20, 5'd4, 5'd1, 3'd5, 5'd14));
      send(r_type(7'h20, 5'd4, 5'd3, 3'd5, 5'd15));
      for (int i = 0; i < 100; i++) begin
         f3 = 3'(i % 8);
         f7 = ((f3 == 3'd0 || f3 == 3'd5) && i % 16 >= 8) ? 7'h20 : 7'h00;
         send(r_type(f7, rand_reg(), rand_reg(), f3, rand_reg()));
      end
      flush();
   endtask

   task automatic forwarding();
      reg_addr_t  prev;
      reg_addr_t  rd;
      logic [2:0] f3;
      logic [6:0] f7;
      prev = 5'd7;
      load_reg(prev, xlen_t'($urandom));
      // each op reads the rd of the one just before it
      for (int i = 0; i < 48; i++) begin
         rd = reg_addr_t'($urandom_range(31, 1));
         f3 = 3'($urandom);
         f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0)) ? 7'h20 : 7'h00;
         if (i % 4 == 3) begin
            send(i_type(12'($urandom), prev, 3'd0, rd));
         end else if (i % 4 == 2) begin
            send(r_type(f7, prev, rand_reg(), f3, rd));
         end else begin
            send(r_type(f7, (i % 4 == 0) ? prev : rand_reg(), prev, f3, rd));
         end
         prev = rd;
      end
      flush();
   endtask

   task automatic x0_writes();
      // x0 as rd still writes back; readers right after see zero
      send(i_type(12'h123, 5'd3, 3'd6, 5'd0));
      send(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd8));
      send(u_type(20'habcde, 5'd0));
      send(i_type(12'h001, 5'd0, 3'd0, 5'd9));
      flush();
   endtask

   task automatic illegal_encodings();
      instr_t ins;
      ins      = instr_t'($urandom);
      ins[6:0] = 7'b1100011;
      send(ins);
      send(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));
      send(r_type(7'h20, 5'd2, 5'd1, 3'd4, 5'd6));
      send(i_type({7'h20, 5'd3}, 5'd1, 3'd1, 5'd7));
      send(i_type({7'h10, 5'd3}, 5'd1, 3'd5, 5'd8));
      flush();
      // read back every register through an x0 destination
      for (int r = 1; r < 32; r++) begin
         send(i_type(12'h000, reg_addr_t'(r), 3'd0, 5'd0));
      end
      flush();
   endtask

   initial begin
      void'($urandom(32'h0051_b756));
      rst_n       = 1'b0;
      // a legal op offered during reset must not reach writeback
      instr_valid = 1'b1;
      instr       = i_type(12'h001, 5'd1, 3'd0, 5'd1);
      pending     = 1'b0;
      exp_rd      = '0;
      exp_data    = '0;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n       = 1'b1;
      instr_valid = 1'b0;
      reset_state();
      imm_ops();
      reg_ops();
      forwarding();
      x0_writes();
      illegal_encodings();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
logic/rv_exec_pkg.sv
logic/reg_read_if.sv
logic/decoded_op_if.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/exec_core.sv
verification/exec_core_tb.sv
